// ==== Makefile ====
TOP := fetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== hdl/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch import fetch_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic [DECODE_PARA-1:0] order,
    input  wire word_t [DECODE_PARA-1:0] pc,
    output logic [DECODE_PARA-1:0]      done,
    output inst_t [DECODE_PARA-1:0]     instr,
    input  wire word_t                  lr_d,
    input  wire logic                   prold_mode,
    input  wire logic                   prold_order,
    input  wire word_t                  prold_pc,
    input  wire inst_t                  prold_data,
    output line_addr_t                  a_inst_mem,
    output logic [FETCH_PARA-1:0]       wen_mem,
    output line_t                       d_inst_mem_w,
    input  wire line_t                  d_inst_mem_r
);

    line_addr_t [DECODE_PARA-1:0]        req_addr;
    line_addr_t                          lr_addr;
    line_addr_t                          prold_addr;
    line_addr_t [FETCH_PREDICT_SIZE-1:0] predict_addr;

    logic                          next_access_order;
    line_addr_t                    next_access_addr;
    logic                          access_order;
    line_addr_t                    access_addr;
    logic                          access_done;
    line_addr_t                    accessed_addr;

    logic [FETCH_PREDICT_SIZE-1:0] predict_found_c;
    logic [FETCH_PREDICT_SIZE-1:0] predict_found_f;
    logic                          lr_found_c;
    logic                          lr_found_f;

    line_t [DECODE_PARA+FETCH_PREDICT_SIZE:0] lookup_line;

    logic [FETCH_PARA-1:0] next_wen_mem;
    inst_t                 prold_data_q;

    // drop the word offset
    always_comb begin
        for (int i = 0; i < DECODE_PARA; i++) begin
            req_addr[i] = pc[i][LEN_MEMISTR_ADDR+LINE_LSB-1:LINE_LSB];
        end
    end

    assign lr_addr = lr_d[LEN_MEMISTR_ADDR+LINE_LSB-1:LINE_LSB];
    assign prold_addr = prold_pc[LEN_MEMISTR_ADDR+LINE_LSB-1:LINE_LSB];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            access_order <= 1'b0;
        end else begin
            access_order <= next_access_order;
        end
    end

    // the loader borrows the address path for writes
    always_ff @(posedge clk) begin
        access_addr <= prold_mode ? prold_addr : next_access_addr;
    end

    assign a_inst_mem = access_addr;

    fetch_timing #(
        .N_FIND(FETCH_PREDICT_SIZE + 1)
    ) u_timing (
        .clk              (clk),
        .arst_n           (arst_n),
        .order            (access_order),
        .done             (access_done),
        .a_inst_fetch_in  (access_addr),
        .a_inst_fetch_out (accessed_addr),
        .find_addr        ({lr_addr, predict_addr}),
        .found            ({lr_found_f, predict_found_f})
    );

    // returned line goes straight into the cache
    fetch_cache #(
        .N_PORTS(DECODE_PARA + FETCH_PREDICT_SIZE + 1)
    ) u_cache (
        .clk          (clk),
        .arst_n       (arst_n),
        .write        (access_done),
        .write_key    (accessed_addr),
        .write_data   (d_inst_mem_r),
        .lookup_order ({{(FETCH_PREDICT_SIZE + 1){1'b1}}, order}),
        .lookup_key   ({lr_addr, predict_addr, req_addr}),
        .lookup_hit   ({lr_found_c, predict_found_c, done}),
        .lookup_data  (lookup_line)
    );

    fetch_predict u_predict (
        .clk               (clk),
        .arst_n            (arst_n),
        .order             (order),
        .done              (done),
        .req_addr          (req_addr),
        .lr_addr           (lr_addr),
        .predict_addr      (predict_addr),
        .predict_fetching  (predict_found_c | predict_found_f),
        .lr_fetching       (lr_found_c | lr_found_f),
        .prold_mode        (prold_mode),
        .next_access_order (next_access_order),
        .next_access_addr  (next_access_addr)
    );

    // word 0 sits in the upper half
    always_comb begin
        int w;
        for (int i = 0; i < DECODE_PARA; i++) begin
            w = FETCH_PARA - 1 - int'(pc[i][LINE_LSB-1:2]);
            instr[i] = lookup_line[i][LEN_INST*w +: LEN_INST];
        end
    end

    // prold write, one bank per strobe
    always_comb begin
        for (int b = 0; b < FETCH_PARA; b++) begin
            next_wen_mem[b] = prold_mode & prold_order
                            & (int'(prold_pc[LINE_LSB-1:2]) == FETCH_PARA - 1 - b);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wen_mem <= '0;
        end else begin
            wen_mem <= next_wen_mem;
        end
    end

    always_ff @(posedge clk) begin
        prold_data_q <= prold_data;
    end

    always_comb begin
        for (int b = 0; b < FETCH_PARA; b++) begin
            d_inst_mem_w[LEN_INST*b +: LEN_INST] = wen_mem[b] ? prold_data_q : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_cache import fetch_pkg::*; #(
    parameter int N_PORTS = 1
) (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     write,
    input  wire line_addr_t               write_key,
    input  wire line_t                    write_data,
    input  wire logic [N_PORTS-1:0]       lookup_order,
    input  wire line_addr_t [N_PORTS-1:0] lookup_key,
    output logic [N_PORTS-1:0]            lookup_hit,
    output line_t [N_PORTS-1:0]           lookup_data
);

    localparam int LOG_DEPTH = $clog2(DEPTH_FETCH_CACHE);

    logic [DEPTH_FETCH_CACHE-1:0] valid;
    line_addr_t                   key  [DEPTH_FETCH_CACHE];
    line_t                        data [DEPTH_FETCH_CACHE];

    // oldest entry, replaced on the next write
    logic [LOG_DEPTH-1:0] wr_ptr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            wr_ptr <= '0;
        end else if (write) begin
            valid[wr_ptr] <= 1'b1;
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            key[wr_ptr] <= write_key;
            data[wr_ptr] <= write_data;
        end
    end

    // all ports search every entry in parallel
    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            lookup_hit[p] = 1'b0;
            lookup_data[p] = '0;
            for (int e = 0; e < DEPTH_FETCH_CACHE; e++) begin
                if (valid[e] && key[e] == lookup_key[p]) begin
                    lookup_hit[p] = lookup_order[p];
                    lookup_data[p] = data[e];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int LEN_WORD = 32;
    localparam int LEN_INST = 32;

    // instructions per cache line
    localparam int LOG_FETCH_PARA = 1;
    localparam int FETCH_PARA = 2 ** LOG_FETCH_PARA;

    localparam int LEN_MEMISTR_ADDR = 8;

    // request lanes from the context manager
    localparam int DECODE_PARA = 2;

    localparam int FETCH_PREDICT_SIZE = 5;
    localparam int DEPTH_FETCH_CACHE = 8;

    // cycles from a_inst_mem to read data
    localparam int MEM_READ_LATENCY = 2;

    // lowest pc bit of the line address
    localparam int LINE_LSB = LOG_FETCH_PARA + 2;

    typedef logic [LEN_WORD-1:0] word_t;
    typedef logic [LEN_INST-1:0] inst_t;
    typedef logic [LEN_MEMISTR_ADDR-1:0] line_addr_t;
    // lower address word in the upper half
    typedef logic [LEN_INST*FETCH_PARA-1:0] line_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_predict.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_predict import fetch_pkg::*; (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [DECODE_PARA-1:0]            order,
    input  wire logic [DECODE_PARA-1:0]            done,
    input  wire line_addr_t [DECODE_PARA-1:0]      req_addr,
    input  wire line_addr_t                        lr_addr,
    output line_addr_t [FETCH_PREDICT_SIZE-1:0]    predict_addr,
    input  wire logic [FETCH_PREDICT_SIZE-1:0]     predict_fetching,
    input  wire logic                              lr_fetching,
    input  wire logic                              prold_mode,
    output logic                                   next_access_order,
    output line_addr_t                             next_access_addr
);

    line_addr_t last_found;
    line_addr_t next_last_found;
    line_addr_t failure_addr;
    line_addr_t predict_base;
    line_addr_t one_predict_addr;

    logic                          find_failure;
    logic                          non_failure_stop;
    logic                          lr_idle;
    logic [FETCH_PREDICT_SIZE-1:0] predict_idle;

    assign find_failure = |(order & ~done);
    // a waiting lane keeps the lr line out of the way
    assign non_failure_stop = ~find_failure;

    // first lane that misses
    always_comb begin
        failure_addr = req_addr[DECODE_PARA-1];
        for (int i = DECODE_PARA - 1; i >= 0; i--) begin
            if (order[i] && !done[i]) begin
                failure_addr = req_addr[i];
            end
        end
    end

    // last lane that hits, else the one from before
    always_comb begin
        next_last_found = last_found;
        for (int i = 0; i < DECODE_PARA; i++) begin
            if (order[i] && done[i]) begin
                next_last_found = req_addr[i];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_found <= '0;
        end else begin
            last_found <= next_last_found;
        end
    end

    assign predict_base = find_failure ? failure_addr : next_last_found;

    always_comb begin
        for (int i = 0; i < FETCH_PREDICT_SIZE; i++) begin
            predict_addr[i] = predict_base + line_addr_t'(i);
        end
    end

    assign predict_idle = ~predict_fetching;
    assign lr_idle = ~lr_fetching;

    // nearest line wins
    always_comb begin
        one_predict_addr = predict_addr[FETCH_PREDICT_SIZE-1];
        for (int i = FETCH_PREDICT_SIZE - 1; i >= 0; i--) begin
            if (predict_idle[i]) begin
                one_predict_addr = predict_addr[i];
            end
        end
    end

    assign next_access_order = ~prold_mode
                             & ((|predict_idle) | (lr_idle & non_failure_stop));
    assign next_access_addr = (|predict_idle) ? one_predict_addr : lr_addr;

endmodule

`default_nettype wire

// ==== hdl/fetch_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_timing import fetch_pkg::*; #(
    parameter int N_FIND = 1
) (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    order,
    output logic                         done,
    input  wire line_addr_t              a_inst_fetch_in,
    output line_addr_t                   a_inst_fetch_out,
    input  wire line_addr_t [N_FIND-1:0] find_addr,
    output logic [N_FIND-1:0]            found
);

    logic       [MEM_READ_LATENCY-1:0] valid_q;
    line_addr_t [MEM_READ_LATENCY-1:0] addr_q;
    logic       [MEM_READ_LATENCY:0]   stage_valid;
    line_addr_t [MEM_READ_LATENCY:0]   stage_addr;

    // stage 0 is the access presented to memory this cycle
    assign stage_valid = {valid_q, order};
    assign stage_addr = {addr_q, a_inst_fetch_in};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= stage_valid[MEM_READ_LATENCY-1:0];
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= stage_addr[MEM_READ_LATENCY-1:0];
    end

    assign done = stage_valid[MEM_READ_LATENCY];
    assign a_inst_fetch_out = stage_addr[MEM_READ_LATENCY];

    // lines in flight
    always_comb begin
        for (int k = 0; k < N_FIND; k++) begin
            found[k] = 1'b0;
            for (int s = 0; s <= MEM_READ_LATENCY; s++) begin
                if (stage_valid[s] && stage_addr[s] == find_addr[k]) begin
                    found[k] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic [DECODE_PARA-1:0]  order,
    input  wire word_t [DECODE_PARA-1:0] pc,
    output logic [DECODE_PARA-1:0]       done,
    output inst_t [DECODE_PARA-1:0]      instr,
    input  wire word_t                   lr_d,
    input  wire logic                    prold_mode,
    input  wire logic                    prold_order,
    input  wire word_t                   prold_pc,
    input  wire inst_t                   prold_data
);

    line_addr_t            a_inst_mem;
    logic [FETCH_PARA-1:0] wen_mem;
    line_t                 d_inst_mem_w;
    line_t                 d_inst_mem_r;

    fetch u_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .order        (order),
        .pc           (pc),
        .done         (done),
        .instr        (instr),
        .lr_d         (lr_d),
        .prold_mode   (prold_mode),
        .prold_order  (prold_order),
        .prold_pc     (prold_pc),
        .prold_data   (prold_data),
        .a_inst_mem   (a_inst_mem),
        .wen_mem      (wen_mem),
        .d_inst_mem_w (d_inst_mem_w),
        .d_inst_mem_r (d_inst_mem_r)
    );

    instr_mem u_mem (
        .clk          (clk),
        .a_inst_mem   (a_inst_mem),
        .wen_mem      (wen_mem),
        .d_inst_mem_w (d_inst_mem_w),
        .d_inst_mem_r (d_inst_mem_r)
    );

endmodule

`default_nettype wire

// ==== hdl/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem import fetch_pkg::*; (
    input  wire logic                  clk,
    input  wire line_addr_t            a_inst_mem,
    input  wire logic [FETCH_PARA-1:0] wen_mem,
    input  wire line_t                 d_inst_mem_w,
    output line_t                      d_inst_mem_r
);

    line_t rd_line;

    // one bank per word of a line
    for (genvar b = 0; b < FETCH_PARA; b++) begin : g_bank
        inst_t mem [2**LEN_MEMISTR_ADDR];
        inst_t rd_q;

        always_ff @(posedge clk) begin
            if (wen_mem[b]) begin
                mem[a_inst_mem] <= d_inst_mem_w[LEN_INST*b +: LEN_INST];
            end
            rd_q <= mem[a_inst_mem];
        end

        assign rd_line[LEN_INST*b +: LEN_INST] = rd_q;
    end

    // second read stage
    always_ff @(posedge clk) begin
        d_inst_mem_r <= rd_line;
    end

endmodule

`default_nettype wire

// ==== sim/fetch_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_assert import fetch_pkg::*; (
    input wire logic                   clk,
    input wire logic                   arst_n,
    input wire logic [DECODE_PARA-1:0] order,
    input wire logic [DECODE_PARA-1:0] done,
    input wire logic [FETCH_PARA-1:0]  wen_mem,
    input wire logic                   prold_mode,
    input wire logic                   access_order
);

    // a lane only answers its own strobe
    done_needs_order: assert property (@(posedge clk) disable iff (!arst_n)
        (done & ~order) == '0)
        else $error("done raised on a lane without order");

    one_bank_write: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(wen_mem))
        else $error("more than one bank written at once");

    no_fetch_in_prold: assert property (@(posedge clk) disable iff (!arst_n)
        prold_mode |=> !access_order)
        else $error("memory access started during program load");

endmodule

bind fetch fetch_assert u_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .order        (order),
    .done         (done),
    .wen_mem      (wen_mem),
    .prold_mode   (prold_mode),
    .access_order (access_order)
);

`default_nettype wire

// ==== sim/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MAX_WAIT = 64;
    localparam int RANDOM_CYCLES = 2000;
    // never requested by the random phase
    localparam int FAR_LINE = 200;

    logic                    clk;
    logic                    arst_n;
    logic [DECODE_PARA-1:0]  order;
    word_t [DECODE_PARA-1:0] pc;
    logic [DECODE_PARA-1:0]  done;
    inst_t [DECODE_PARA-1:0] instr;
    word_t                   lr_d;
    logic                    prold_mode;
    logic                    prold_order;
    word_t                   prold_pc;
    inst_t                   prold_data;

    inst_t model_mem [512];
    int    seed = 99121;
    int    cycles = 0;
    int    mismatch_errors = 0;
    int    other_errors = 0;
    int    wait_n [DECODE_PARA];
    logic  retire [DECODE_PARA];
    int    base_line;

    fetch_top UUT (
        .clk         (clk),
        .arst_n      (arst_n),
        .order       (order),
        .pc          (pc),
        .done        (done),
        .instr       (instr),
        .lr_d        (lr_d),
        .prold_mode  (prold_mode),
        .prold_order (prold_order),
        .prold_pc    (prold_pc),
        .prold_data  (prold_data)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    // pc of a random word in lines 0 .. n_lines-1
    function automatic word_t rand_pc(input int n_lines);
        word_t p;
        p = word_t'(({$random(seed)} % n_lines) << 3);
        p[2] = $random(seed);
        return p;
    endfunction

    function automatic word_t line_pc(input int line, input logic word);
        word_t p;
        p = word_t'(line << 3);
        p[2] = word;
        return p;
    endfunction

    task automatic check_word(input int lane);
        inst_t expected;
        expected = model_mem[pc[lane][10:2]];
        assert (instr[lane] == expected) else begin
            mismatch_errors++;
            $display("mismatch at %0t: lane %0d pc %h instr %h expected %h",
                     $time, lane, pc[lane], instr[lane], expected);
        end
    endtask

    // holds the request until done, then drops order
    task automatic wait_done(input int lane);
        int   n;
        logic got;
        n = 0;
        got = 1'b0;
        while (!got && n < MAX_WAIT) begin
            @(negedge clk);
            if (done[lane]) begin
                check_word(lane);
                got = 1'b1;
            end else begin
                n++;
            end
        end
        assert (got) else begin
            other_errors++;
            $display("lane %0d request for pc %h not done within %0d cycles",
                     lane, pc[lane], MAX_WAIT);
        end
        @(posedge clk);
        order[lane] <= 1'b0;
    endtask

    initial begin
        arst_n = 1'b0;
        order = '0;
        pc = '0;
        lr_d = '0;
        // no fetch before the program is loaded
        prold_mode = 1'b1;
        prold_order = 1'b0;
        prold_pc = '0;
        prold_data = '0;
        for (int a = 0; a < 512; a++) begin
            model_mem[a] = $random(seed);
        end

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;

        // idle after reset
        repeat (8) begin
            @(negedge clk);
            assert (done == '0) else begin
                other_errors++;
                $display("done raised while order is low after reset");
            end
        end

        // program load, one word per strobe, requests pending on both lanes
        @(posedge clk);
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            prold_order <= 1'b1;
            prold_pc <= word_t'(a << 2);
            prold_data <= model_mem[a];
            order <= $random(seed);
            pc[0] <= rand_pc(256);
            pc[1] <= rand_pc(256);
            @(negedge clk);
            assert (done == '0) else begin
                other_errors++;
                $display("done raised during program load");
            end
        end
        @(posedge clk);
        prold_order <= 1'b0;
        order <= '0;
        repeat (4) @(posedge clk);
        prold_mode <= 1'b0;
        lr_d <= rand_pc(128);

        // random requests on both lanes
        for (int i = 0; i < DECODE_PARA; i++) begin
            wait_n[i] = 0;
        end
        repeat (RANDOM_CYCLES) begin
            @(negedge clk);
            for (int i = 0; i < DECODE_PARA; i++) begin
                retire[i] = 1'b1;
                if (order[i] && done[i]) begin
                    check_word(i);
                end else if (order[i]) begin
                    wait_n[i]++;
                    retire[i] = wait_n[i] > MAX_WAIT;
                    assert (wait_n[i] <= MAX_WAIT) else begin
                        other_errors++;
                        $display("lane %0d request for pc %h not done within %0d cycles",
                                 i, pc[i], MAX_WAIT);
                    end
                end
            end
            @(posedge clk);
            for (int i = 0; i < DECODE_PARA; i++) begin
                if (retire[i]) begin
                    order[i] <= $random(seed);
                    pc[i] <= rand_pc(128);
                    wait_n[i] = 0;
                end
            end
        end
        @(posedge clk);
        order <= '0;
        repeat (4) @(posedge clk);

        // sequential prefetch after a hit on line L
        base_line = {$random(seed)} % 100;
        pc[0] <= line_pc(base_line, $random(seed));
        order[0] <= 1'b1;
        wait_done(0);
        repeat (30) @(posedge clk);
        pc[0] <= line_pc(base_line + 3, $random(seed));
        order[0] <= 1'b1;
        @(negedge clk);
        assert (done[0]) else begin
            other_errors++;
            $display("line %0d not prefetched after a hit on line %0d",
                     base_line + 3, base_line);
        end
        if (done[0]) begin
            check_word(0);
        end
        @(posedge clk);
        order[0] <= 1'b0;

        // link register prefetch
        lr_d <= rand_pc(100);
        repeat (30) @(posedge clk);
        pc[1] <= lr_d;
        order[1] <= 1'b1;
        pc[0] <= line_pc(FAR_LINE, $random(seed));
        order[0] <= 1'b1;
        @(negedge clk);
        assert (done[1]) else begin
            other_errors++;
            $display("link register line was not prefetched");
        end
        if (done[1]) begin
            check_word(1);
        end
        // the other lane still waits for its line
        assert (!done[0]) else begin
            other_errors++;
            $display("lane 0 done before its line could be fetched");
        end
        @(posedge clk);
        order[1] <= 1'b0;
        wait_done(0);
        repeat (4) @(posedge clk);

        $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/fetch_pkg.sv
hdl/fetch_timing.sv
hdl/fetch_cache.sv
hdl/fetch_predict.sv
hdl/fetch.sv
hdl/instr_mem.sv
hdl/fetch_top.sv
sim/fetch_assert.sv
sim/fetch_tb.sv
